//--- tb.f
hw/ft245_pkg.sv
hw/host_cmd_pkg.sv
hw/wishbone_if.sv
hw/ft245_ifc.sv
hw/host_cmd_engine.sv
hw/wb_reg_bank.sv
hw/ft245_wb_bridge.sv
tests/bridge_props.sv
tests/tb_ft245_bridge.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the FT245 bridge testbench with Verilator.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_ft245_bridge -f tb.f -o tb_sim \
	&& ./obj_dir/tb_sim | tee sim.log \
	|| { echo "build or run failed"; exit 1; }

# the run counts as passed only if the testbench reported it.
grep -qx "Done: no errors" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- tests/tb_ft245_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ft245_bridge;
	import host_cmd_pkg::*;

	logic       clk;
	logic       reset;
	logic [7:0] data_in;
	logic [7:0] data_out;
	logic       dir_out;
	logic       rxf;
	logic       txe;
	logic       rd;
	logic       wr;
	logic       siwu;

	// chip model state.
	logic [7:0]  host_q [$];	// bytes from the host, head goes out first.
	logic [7:0]  reply_q [$];	// bytes caught on wr pulses.
	logic [7:0]  exp_q [$];
	string       name_q [$];
	logic [7:0]  model_regs [16];
	logic [15:0] lfsr_state = 16'd5525;
	logic [7:0]  wr_count = 8'd0;
	logic [7:0]  siwu_count = 8'd0;
	logic        rd_prev = 1'b0;
	logic        txe_force_low = 1'b0;
	logic        txe_random = 1'b0;
	int          byte_total = 0;
	int          cycle_count = 0;
	int          checks = 0;
	int          value_errors = 0;
	int          other_errors = 0;

	ft245_wb_bridge DUT (
		.clk      (clk),
		.reset    (reset),
		.data_in  (data_in),
		.data_out (data_out),
		.dir_out  (dir_out),
		.rxf      (rxf),
		.txe      (txe),
		.rd       (rd),
		.wr       (wr),
		.siwu     (siwu)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ********************
	// helpers.
	// ********************

	// taps 16, 14, 13, 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [7:0] v);
		v = 8'h00;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[6:0], lfsr_state[0]};	// one step per bit.
		end
	endtask

	// packet rules applied to the register model.
	function automatic logic [7:0] expected_reply(input logic [7:0] op, input logic [7:0] adr,
		input logic [7:0] dat);
		if (op == 8'h01)
		begin
			model_regs[adr[3:0]] = dat;	// only the low nibble selects.
			return 8'hAA;
		end
		else if (op == 8'h02)
			return model_regs[adr[3:0]];
		return 8'hEE;
	endfunction

	task automatic check_value(input string test, input logic [7:0] expected,
		input logic [7:0] actual);
		checks++;
		if (actual !== expected)
		begin
			value_errors++;
			$display("** Error %s: expected 0x%02h, actual 0x%02h", test, expected, actual);
		end
	endtask

	task automatic send_packet(input string name, input logic [7:0] op, input logic [7:0] adr,
		input logic [7:0] dat);
		host_q.push_back(op);
		byte_total++;
		if (op == OP_WRITE || op == OP_READ)
		begin
			host_q.push_back(adr);
			byte_total++;
		end
		if (op == OP_WRITE)
		begin
			host_q.push_back(dat);
			byte_total++;
		end
		exp_q.push_back(expected_reply(op, adr, dat));
		name_q.push_back(name);
	endtask

	task automatic wait_replies();
		while (exp_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic report_result();
		$display("Checks %0d, value errors %0d, other errors %0d", checks, value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
	endtask

	// ********************
	// chip model.
	// ********************

	initial
	begin
		logic [7:0] gap;
		data_in = 8'h00;
		rxf     = 1'b0;
		txe     = 1'b1;
		forever
		begin
			@(posedge clk);
			#2;
			if (rd && !rd_prev && host_q.size() != 0)
				data_in = host_q[0];	// held through the sample cycle.
			if (!rd && rd_prev && host_q.size() != 0)
				void'(host_q.pop_front());
			if (wr)
			begin
				reply_q.push_back(data_out);
				wr_count++;
			end
			if (siwu)
				siwu_count++;
			rd_prev = rd;
			rxf = (host_q.size() != 0);
			if (txe_force_low)
				txe = 1'b0;
			else if (txe_random)
			begin
				take_bits(2, gap);
				txe = (gap[1:0] != 2'b00);	// low about one cycle in four.
			end
			else
				txe = 1'b1;
		end
	end

	// compares each reply in arrival order.
	initial
	begin
		logic [7:0] got;
		forever
		begin
			@(posedge clk);
			while (reply_q.size() != 0)
			begin
				got = reply_q.pop_front();
				if (exp_q.size() == 0)
				begin
					$display("Unexpected reply byte 0x%02h with no packet waiting for one.", got);
					other_errors++;
				end
				else
					check_value(name_q.pop_front(), exp_q.pop_front(), got);
			end
		end
	end

	// limit grows with every queued packet byte.
	initial
	begin
		while (cycle_count <= 40 * byte_total + 200)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: no complete set of replies after %0d cycles.", cycle_count);
		other_errors++;
		report_result();
		$finish;
	end

	// ********************
	// tests.
	// ********************

	initial
	begin
		logic [7:0] sel;
		logic [7:0] op;
		logic [7:0] adr;
		logic [7:0] dat;
		logic [7:0] wr_before;

		reset = 1'b1;
		for (int i = 0; i < 16; i++)
			model_regs[i] = 8'h00;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;

		// strobes stay quiet with nothing to move.
		for (int i = 0; i < 4; i++)
		begin
			@(negedge clk);
			check_value("reset_idle", 8'h00, {4'b0000, rd, wr, dir_out, siwu});
		end
		@(posedge clk);

		send_packet("write_read", OP_WRITE, 8'h09, 8'hC3);
		send_packet("write_read", OP_READ, 8'h09, 8'h00);
		wait_replies();

		send_packet("bad_opcode", 8'h7F, 8'h00, 8'h00);
		send_packet("after_bad", OP_WRITE, 8'h05, 8'h5A);
		send_packet("after_bad", OP_READ, 8'h05, 8'h00);
		wait_replies();

		send_packet("addr_wrap", OP_WRITE, 8'h13, 8'h6E);
		send_packet("addr_wrap", OP_READ, 8'h03, 8'h00);
		wait_replies();

		// txe low for a stretch, replies pile up.
		txe_force_low = 1'b1;
		wr_before = wr_count;
		send_packet("backpressure", OP_WRITE, 8'h07, 8'h3C);
		send_packet("backpressure", OP_READ, 8'h07, 8'h00);
		repeat (100) @(posedge clk);
		check_value("backpressure_no_wr", wr_before, wr_count);
		check_value("backpressure_pending", 8'd2, 8'(exp_q.size()));
		txe_force_low = 1'b0;
		wait_replies();

		for (int i = 0; i < 40; i++)
		begin
			take_bits(2, sel);
			take_bits(8, adr);
			take_bits(8, dat);
			if (sel[1:0] == 2'd0)
			begin
				take_bits(8, op);
				if (op == OP_WRITE || op == OP_READ)
					op = op ^ 8'h40;	// keep it unknown.
			end
			else if (sel[1:0] == 2'd3)
				op = OP_READ;
			else
				op = OP_WRITE;
			send_packet("random_pkt", op, adr, dat);
		end
		txe_random = 1'b1;
		wait_replies();
		txe_random = 1'b0;

		repeat (20) @(posedge clk);
		if (host_q.size() != 0)
		begin
			$display("The bridge left %0d host bytes unread.", host_q.size());
			other_errors++;
		end
		// every reply byte ends with one siwu pulse.
		check_value("siwu_pulses", wr_count, siwu_count);
		report_result();
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/bridge_props.sv
`timescale 1ns/100ps
`default_nettype none

module bridge_props (
	input logic clk,
	input logic reset,
	input logic wr,
	input logic rd,
	input logic dir_out,
	input logic cyc,
	input logic stb,
	input logic ack
);

	// ********************
	// pin sequencing.
	// ********************

	a_wr_dir: assert property (@(posedge clk) disable iff (reset) wr |-> dir_out)
		else $error("wr strobe while dir_out is low.");
	a_rd_dir: assert property (@(posedge clk) disable iff (reset) !(rd && dir_out))
		else $error("rd strobe while the bus drives out.");
	a_wr_rd: assert property (@(posedge clk) disable iff (reset) !(wr && rd))
		else $error("wr and rd high together.");

	// wishbone classic rules.
	a_stb_cyc: assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
		else $error("stb without cyc.");
	a_ack_stb: assert property (@(posedge clk) disable iff (reset) ack |-> stb)
		else $error("ack while stb is low.");

endmodule

bind ft245_wb_bridge bridge_props u_props (
	.clk     (clk),
	.reset   (reset),
	.wr      (wr),
	.rd      (rd),
	.dir_out (dir_out),
	.cyc     (wb.cyc),
	.stb     (wb.stb),
	.ack     (wb.ack)
);

`default_nettype wire

//--- hw/ft245_wb_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module ft245_wb_bridge (
	input  logic             clk,
	input  logic             reset,

	// FT245 chip pins, all active high.
	input  ft245_pkg::byte_t data_in,
	output ft245_pkg::byte_t data_out,
	output logic             dir_out,
	input  logic             rxf,	// byte available.
	input  logic             txe,	// space free.
	output logic             rd,
	output logic             wr,
	output logic             siwu
);

	// byte channels between the pin sequencer and the engine.
	ft245_pkg::byte_t rx_data;
	logic             rx_seq;
	logic             rx_ack;
	ft245_pkg::byte_t tx_data;
	logic             tx_seq;
	logic             tx_ack;

	wishbone_if wb ();

	ft245_ifc u_ifc (
		.clk      (clk),
		.reset    (reset),
		.rx_data  (rx_data),
		.rx_seq   (rx_seq),
		.rx_ack   (rx_ack),
		.tx_data  (tx_data),
		.tx_seq   (tx_seq),
		.tx_ack   (tx_ack),
		.data_in  (data_in),
		.data_out (data_out),
		.dir_out  (dir_out),
		.rd       (rd),
		.wr       (wr),
		.siwu     (siwu),
		.rxf      (rxf),
		.txe      (txe)
	);

	host_cmd_engine u_engine (
		.clk     (clk),
		.reset   (reset),
		.rx_data (rx_data),
		.rx_seq  (rx_seq),
		.rx_ack  (rx_ack),
		.tx_data (tx_data),
		.tx_seq  (tx_seq),
		.tx_ack  (tx_ack),
		.bus     (wb.master)
	);

	wb_reg_bank u_bank (
		.clk   (clk),
		.reset (reset),
		.bus   (wb.slave)
	);

endmodule

`default_nettype wire

//--- hw/wb_reg_bank.sv
`timescale 1ns/100ps
`default_nettype none

module wb_reg_bank (
	input  logic      clk,
	input  logic      reset,
	wishbone_if.slave bus
);
	import host_cmd_pkg::*;

	wb_dat_t                 regs [REG_COUNT];
	logic [REG_ADR_BITS-1:0] sel;
	logic                    ack_q;

	// only the low address bits select a register, so the bank repeats.
	assign sel = bus.adr[REG_ADR_BITS-1:0];

	assign bus.ack   = ack_q;
	assign bus.dat_r = regs[sel];	// valid while ack is high.

	// ********************
	// ack and write port.
	// ********************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ack_q <= 1'b0;
			for (int i = 0; i < REG_COUNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else
		begin
			// one cycle after stb, and low again on the next edge.
			ack_q <= bus.cyc && bus.stb && !ack_q;

			if (ack_q && bus.we)
				regs[sel] <= bus.dat_w;
		end
	end

endmodule

`default_nettype wire

//--- hw/host_cmd_engine.sv
`timescale 1ns/100ps
`default_nettype none

module host_cmd_engine (
	input  logic             clk,
	input  logic             reset,

	input  ft245_pkg::byte_t rx_data,
	input  logic             rx_seq,
	output logic             rx_ack,	// copy of rx_seq once the byte is taken.

	output ft245_pkg::byte_t tx_data,
	output logic             tx_seq,	// toggled once per packet.
	input  logic             tx_ack,

	wishbone_if.master       bus
);
	import ft245_pkg::*;
	import host_cmd_pkg::*;

	cmd_state_t state;
	byte_t      opcode;
	wb_adr_t    adr;
	wb_dat_t    dat;
	byte_t      reply;
	logic       rx_avail;
	logic       tx_free;
	logic       op_known;

	assign rx_avail = (rx_seq != rx_ack);
	assign tx_free  = (tx_seq == tx_ack);
	assign op_known = (rx_data == OP_WRITE) || (rx_data == OP_READ);

	// ********************
	// wishbone master.
	// ********************

	// cyc and stb fall in the cycle after ack, when the state has moved on.
	assign bus.cyc   = (state == cmd_bus);
	assign bus.stb   = (state == cmd_bus);
	assign bus.we    = (opcode == OP_WRITE);
	assign bus.adr   = adr;
	assign bus.dat_w = dat;

	// ********************
	// packet walk.
	// ********************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state  <= cmd_get_op;
			rx_ack <= 1'b0;
			tx_seq <= 1'b0;
		end
		else
		begin
			case (state)
				cmd_get_op:
					if (rx_avail)
					begin
						rx_ack <= rx_seq;
						if (op_known)
							state <= cmd_get_adr;
						else
							state <= cmd_send;	// unknown opcode ends the packet.
					end
				cmd_get_adr:
					if (rx_avail)
					begin
						rx_ack <= rx_seq;
						if (opcode == OP_WRITE)
							state <= cmd_get_dat;
						else
							state <= cmd_bus;
					end
				cmd_get_dat:
					if (rx_avail)
					begin
						rx_ack <= rx_seq;
						state  <= cmd_bus;
					end
				cmd_bus:
					if (bus.ack)
						state <= cmd_send;
				cmd_send:
					// waits here while the previous reply is still queued.
					if (tx_free)
					begin
						tx_seq <= ~tx_seq;
						state  <= cmd_get_op;
					end
				default:
					state <= cmd_get_op;
			endcase
		end
	end

	// ********************
	// packet fields and reply.
	// ********************

	always_ff @(posedge clk)
	begin
		case (state)
			cmd_get_op:
				if (rx_avail)
				begin
					opcode <= rx_data;
					reply  <= RSP_BAD_OPCODE;	// replaced once a bus cycle runs.
				end
			cmd_get_adr:
				if (rx_avail)
					adr <= rx_data;
			cmd_get_dat:
				if (rx_avail)
					dat <= rx_data;
			cmd_bus:
				if (bus.ack)
					reply <= bus.we ? RSP_WRITE_DONE : bus.dat_r;
			cmd_send:
				if (tx_free)
					tx_data <= reply;	// steady until the next toggle.
			default:
				reply <= RSP_BAD_OPCODE;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/ft245_ifc.sv
`timescale 1ns/100ps
`default_nettype none

module ft245_ifc (
	input  logic             clk,
	input  logic             reset,

	output ft245_pkg::byte_t rx_data,
	output logic             rx_seq,	// toggles when a byte is ready.
	input  logic             rx_ack,

	input  ft245_pkg::byte_t tx_data,
	input  logic             tx_seq,	// toggle to send tx_data.
	output logic             tx_ack,

	input  ft245_pkg::byte_t data_in,
	output ft245_pkg::byte_t data_out,
	output logic             dir_out,
	output logic             rd,
	output logic             wr,
	output logic             siwu,
	input  logic             rxf,
	input  logic             txe
);
	import ft245_pkg::*;

	ft245_state_t state;
	ft245_state_t state_next;
	byte_t        data_out_q;
	logic         tx_ready;
	logic         rx_ready;
	logic         launch;

	assign tx_ready = (tx_seq != tx_ack) && txe;
	assign rx_ready = (rx_seq == rx_ack) && rxf;

	// ********************
	// next state and strobes.
	// ********************

	always_comb
	begin
		state_next = state;
		launch     = 1'b0;
		dir_out    = 1'b0;
		rd         = 1'b0;
		wr         = 1'b0;
		siwu       = 1'b0;

		case (state)
			ft_idle:
				if (tx_ready)
				begin
					// transmit wins over receive.
					state_next = ft_tx_setup;
					launch     = 1'b1;
					dir_out    = 1'b1;
				end
				else if (rx_ready)
					state_next = ft_rx_assert;
			ft_tx_setup:
			begin
				state_next = ft_tx_assert;
				dir_out    = 1'b1;
				wr         = 1'b1;
			end
			ft_tx_assert:
			begin
				state_next = ft_tx_hold;
				dir_out    = 1'b1;
			end
			ft_tx_hold:
			begin
				state_next = ft_idle;
				siwu       = 1'b1;	// flush the chip's send buffer.
			end
			ft_rx_assert:
			begin
				state_next = ft_rx_hold;
				rd         = 1'b1;
			end
			ft_rx_hold:
			begin
				state_next = ft_rx_sample;
				rd         = 1'b1;
			end
			ft_rx_sample:
				state_next = ft_idle;
			default:
				state_next = ft_idle;
		endcase
	end

	// byte goes on the bus in the launch cycle already.
	assign data_out = launch ? tx_data : data_out_q;

	// ********************
	// registers.
	// ********************

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state  <= ft_idle;
			rx_seq <= 1'b0;
			tx_ack <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (launch)
				tx_ack <= tx_seq;	// frees the engine for the next reply.
			if (state == ft_rx_sample)
				rx_seq <= ~rx_seq;
		end
	end

	always_ff @(posedge clk)
	begin
		if (launch)
			data_out_q <= tx_data;
		if (state == ft_rx_sample)
			rx_data <= data_in;	// rd is already low again.
	end

endmodule

`default_nettype wire

//--- hw/wishbone_if.sv
`timescale 1ns/100ps
`default_nettype none

interface wishbone_if;
	import host_cmd_pkg::*;

	logic    cyc;
	logic    stb;
	logic    we;
	wb_adr_t adr;
	wb_dat_t dat_w;
	wb_dat_t dat_r;
	logic    ack;	// one cycle per transfer.

	// classic cycle, single transfer.
	modport master (
		output cyc, stb, we, adr, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

`default_nettype wire

//--- hw/host_cmd_pkg.sv
`default_nettype none

package host_cmd_pkg;

	// ********************
	// wishbone widths.
	// ********************

	typedef logic [7:0] wb_adr_t;
	typedef logic [7:0] wb_dat_t;

	localparam int REG_COUNT    = 16;
	localparam int REG_ADR_BITS = $clog2(REG_COUNT);	// upper address bits are ignored.

	// ********************
	// packet protocol.
	// ********************

	localparam logic [7:0] OP_WRITE       = 8'h01;	// opcode, address, data.
	localparam logic [7:0] OP_READ        = 8'h02;	// opcode, address.
	localparam logic [7:0] RSP_WRITE_DONE = 8'hAA;
	localparam logic [7:0] RSP_BAD_OPCODE = 8'hEE;	// one-byte packet.

	// command engine states.
	typedef enum logic [2:0] {
		cmd_get_op  = 3'd0,
		cmd_get_adr = 3'd1,
		cmd_get_dat = 3'd2,	// writes only.
		cmd_bus     = 3'd3,
		cmd_send    = 3'd4
	} cmd_state_t;

endpackage

`default_nettype wire

//--- hw/ft245_pkg.sv
`default_nettype none

package ft245_pkg;

	// ********************
	// chip bus data.
	// ********************

	typedef logic [7:0] byte_t;	// one byte on the pins and the byte channels.

	// ********************
	// pin sequencer states.
	// ********************

	// transmit runs setup, assert, hold; receive runs assert, hold, sample.
	typedef enum logic [2:0] {
		ft_idle      = 3'd0,
		ft_tx_setup  = 3'd1,	// wr strobe.
		ft_tx_assert = 3'd2,
		ft_tx_hold   = 3'd3,	// siwu pulse.
		ft_rx_assert = 3'd4,
		ft_rx_hold   = 3'd5,
		ft_rx_sample = 3'd6	// data_in captured here.
	} ft245_state_t;

endpackage

`default_nettype wire
